/* src/addr_decode_pkg.sv */
package addr_decode_pkg;

    // instruction byte window and decoder positions
    localparam int window_bytes  = 6;
    localparam int num_positions = 5;
    localparam int max_prefixes  = 4;

    // modrm field codes
    localparam logic [1:0] mod_reg_only = 2'b11;
    localparam logic [2:0] rm_sib       = 3'b100;
    localparam logic [2:0] rm_disp32    = 3'b101;
    localparam logic [2:0] rm_disp16    = 3'b110;

    // register numbers used by the 16-bit table
    localparam logic [2:0] reg_bx = 3'b011;
    localparam logic [2:0] reg_bp = 3'b101;
    localparam logic [2:0] reg_si = 3'b110;
    localparam logic [2:0] reg_di = 3'b111;

    typedef logic [2:0] reg_t;

    // byte count, 0 to 6
    typedef logic [2:0] len_t;

    typedef struct packed {
        logic [1:0] mod;
        logic [2:0] reg_op;
        logic [2:0] rm;
    } modrm_t;

    typedef struct packed {
        logic [1:0] scale;
        logic [2:0] index;
        logic [2:0] base;
    } sib_t;

    // a window byte is modrm to one decoder and sib to the one before it
    typedef union packed {
        modrm_t modrm;
        sib_t   sib;
    } ea_byte_u;

    typedef struct packed {
        ea_byte_u [window_bytes-1:0] window;
        logic                        has_modrm;
        logic [max_prefixes-1:0]     prefix_onehot;
        logic                        two_byte_op;
        logic                        addr16;
    } decode_req_t;

    typedef struct packed {
        len_t       total_len;
        len_t       disp_len;
        reg_t       base_reg;
        reg_t       index_reg;
        logic       use_base;
        logic       use_index;
        logic [1:0] scale;
        logic       has_sib;
    } ea_info_t;

endpackage

/* src/ea_length_decode.sv */
`timescale 1ns/1ps

module ea_length_decode (
    input  addr_decode_pkg::modrm_t modrm,
    input  logic                    is_sib,
    input  logic                    has_modrm,
    input  logic                    addr16,
    output addr_decode_pkg::len_t   disp_len,
    output addr_decode_pkg::len_t   total_len
);

    logic  direct_disp;
    logic  sib_len;

    // mod 00 with the displacement-only rm of the current mode
    always_comb begin
        if (addr16) begin
            direct_disp = (modrm.rm == addr_decode_pkg::rm_disp16);
        end else begin
            direct_disp = (modrm.rm == addr_decode_pkg::rm_disp32);
        end
    end

    always_comb begin
        disp_len = 3'd0;
        if (has_modrm) begin
            case (modrm.mod)
                2'b00: begin
                    if (direct_disp) begin
                        disp_len = addr16 ? 3'd2 : 3'd4;
                    end
                end
                2'b01: begin
                    disp_len = 3'd1;
                end
                2'b10: begin
                    disp_len = addr16 ? 3'd2 : 3'd4;
                end
                default: begin
                    disp_len = 3'd0;
                end
            endcase
        end
    end

    assign sib_len = has_modrm & is_sib;

    // modrm byte, optional sib byte, then displacement
    always_comb begin
        if (has_modrm) begin
            total_len = 3'd1 + {2'b00, sib_len} + disp_len;
        end else begin
            total_len = 3'd0;
        end
    end

endmodule

/* src/ea_register_decode.sv */
`timescale 1ns/1ps

module ea_register_decode (
    input  addr_decode_pkg::modrm_t modrm,
    input  addr_decode_pkg::sib_t   sib,
    input  logic                    is_sib,
    input  logic                    has_modrm,
    input  logic                    addr16,
    output addr_decode_pkg::reg_t   base_reg,
    output logic                    use_base,
    output addr_decode_pkg::reg_t   index_reg,
    output logic                    use_index,
    output logic [1:0]              scale
);

    logic reg_operand;
    logic disp_only32;

    assign reg_operand = (modrm.mod == addr_decode_pkg::mod_reg_only);
    assign disp_only32 = (modrm.mod == 2'b00) && (modrm.rm == addr_decode_pkg::rm_disp32);

    always_comb begin
        base_reg  = 3'd0;
        use_base  = 1'b0;
        index_reg = 3'd0;
        use_index = 1'b0;
        scale     = 2'd0;
        if (has_modrm) begin
            if (!addr16 || reg_operand) begin
                if (is_sib) begin
                    base_reg  = sib.base;
                    use_base  = 1'b1;
                    index_reg = sib.index;
                    use_index = 1'b1;
                    scale     = sib.scale;
                end else if (!disp_only32) begin
                    base_reg = modrm.rm;
                    use_base = 1'b1;
                end
            end else begin
                // 16-bit memory forms, base half of the table
                case (modrm.rm)
                    3'b000, 3'b001, 3'b111: begin
                        base_reg = addr_decode_pkg::reg_bx;
                        use_base = 1'b1;
                    end
                    3'b010, 3'b011: begin
                        base_reg = addr_decode_pkg::reg_bp;
                        use_base = 1'b1;
                    end
                    addr_decode_pkg::rm_disp16: begin
                        // mod 00 here is disp16 alone
                        if (modrm.mod != 2'b00) begin
                            base_reg = addr_decode_pkg::reg_bp;
                            use_base = 1'b1;
                        end
                    end
                    default: begin
                        use_base = 1'b0;
                    end
                endcase
                // index half
                case (modrm.rm)
                    3'b000, 3'b010, 3'b100: begin
                        index_reg = addr_decode_pkg::reg_si;
                        use_index = 1'b1;
                    end
                    3'b001, 3'b011, 3'b101: begin
                        index_reg = addr_decode_pkg::reg_di;
                        use_index = 1'b1;
                    end
                    default: begin
                        use_index = 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

/* src/modrm_decoder.sv */
`timescale 1ns/1ps

module modrm_decoder (
    input  addr_decode_pkg::ea_byte_u modrm_byte,
    input  addr_decode_pkg::ea_byte_u sib_byte,
    input  logic                      has_modrm,
    input  logic                      addr16,
    output addr_decode_pkg::ea_info_t info
);

    addr_decode_pkg::modrm_t modrm;
    addr_decode_pkg::sib_t   sib;
    logic                    is_sib;
    addr_decode_pkg::len_t   disp_len;
    addr_decode_pkg::len_t   total_len;
    addr_decode_pkg::reg_t   base_reg;
    addr_decode_pkg::reg_t   index_reg;
    logic                    use_base;
    logic                    use_index;
    logic [1:0]              scale;

    assign modrm = modrm_byte.modrm;
    assign sib   = sib_byte.sib;

    // sib only exists for 32-bit memory forms
    assign is_sib = has_modrm && !addr16
                 && (modrm.mod != addr_decode_pkg::mod_reg_only)
                 && (modrm.rm == addr_decode_pkg::rm_sib);

    ea_length_decode length_i (
        .modrm     (modrm),
        .is_sib    (is_sib),
        .has_modrm (has_modrm),
        .addr16    (addr16),
        .disp_len  (disp_len),
        .total_len (total_len)
    );

    ea_register_decode register_i (
        .modrm     (modrm),
        .sib       (sib),
        .is_sib    (is_sib),
        .has_modrm (has_modrm),
        .addr16    (addr16),
        .base_reg  (base_reg),
        .use_base  (use_base),
        .index_reg (index_reg),
        .use_index (use_index),
        .scale     (scale)
    );

    always_comb begin
        info.total_len = total_len;
        info.disp_len  = disp_len;
        info.base_reg  = base_reg;
        info.index_reg = index_reg;
        info.use_base  = use_base;
        info.use_index = use_index;
        info.scale     = scale;
        info.has_sib   = is_sib;
    end

endmodule

/* src/ea_select_stage.sv */
`timescale 1ns/1ps

module ea_select_stage (
    input  logic                                                       clk,
    input  logic                                                       rst,
    input  addr_decode_pkg::ea_info_t [addr_decode_pkg::num_positions-1:0] candidates,
    input  logic [addr_decode_pkg::max_prefixes-1:0]                   prefix_onehot,
    input  logic                                                       two_byte_op,
    input  logic                                                       in_valid,
    output logic                                                       in_ready,
    output logic                                                       out_valid,
    input  logic                                                       out_ready,
    output addr_decode_pkg::ea_info_t                                  out_data
);

    logic [1:0]                prefix_count;
    logic [2:0]                position;
    addr_decode_pkg::ea_info_t selected;
    logic                      accept;

    // one-hot to binary, mask is expected to have a single bit set
    always_comb begin
        prefix_count = 2'd0;
        for (int i = 0; i < addr_decode_pkg::max_prefixes; i++) begin
            if (prefix_onehot[i]) begin
                prefix_count = 2'(i);
            end
        end
    end

    // modrm follows the prefixes and the 0f escape byte
    assign position = {1'b0, prefix_count} + {2'b00, two_byte_op};
    assign selected = candidates[position];

    // register empty or draining this cycle
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_data <= selected;
        end
    end

endmodule

/* src/addressing_decode.sv */
`timescale 1ns/1ps

module addressing_decode (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  addr_decode_pkg::decode_req_t in_data,
    output logic                         out_valid,
    input  logic                         out_ready,
    output addr_decode_pkg::ea_info_t    out_data
);

    addr_decode_pkg::ea_info_t [addr_decode_pkg::num_positions-1:0] candidates;

    // one decoder per possible modrm position
    for (genvar k = 0; k < addr_decode_pkg::num_positions; k++) begin : g_pos
        modrm_decoder decoder_i (
            .modrm_byte (in_data.window[k]),
            .sib_byte   (in_data.window[k+1]),
            .has_modrm  (in_data.has_modrm),
            .addr16     (in_data.addr16),
            .info       (candidates[k])
        );
    end

    ea_select_stage select_i (
        .clk           (clk),
        .rst           (rst),
        .candidates    (candidates),
        .prefix_onehot (in_data.prefix_onehot),
        .two_byte_op   (in_data.two_byte_op),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_data      (out_data)
    );

endmodule

/* tests/addressing_decode_properties.sv */
`timescale 1ns/1ps

module addressing_decode_properties (
    input logic                                     clk,
    input logic                                     rst,
    input logic [addr_decode_pkg::max_prefixes-1:0] prefix_onehot,
    input logic                                     in_valid,
    input logic                                     out_valid,
    input logic                                     out_ready,
    input addr_decode_pkg::ea_info_t                out_data
);

    // a request names exactly one prefix count
    prefix_onehot_a: assert property (
        @(posedge clk) disable iff (rst) in_valid |-> $onehot(prefix_onehot)
    ) else $error("prefix mask is not one-hot while in_valid is high");

    // held result must not move while the consumer stalls
    stall_stable_a: assert property (
        @(posedge clk) disable iff (rst) (out_valid && !out_ready) |=> $stable(out_data)
    ) else $error("out_data changed while out_valid was high and out_ready low");

    reset_empty_a: assert property (
        @(posedge clk) rst |=> !out_valid
    ) else $error("out_valid is high in the cycle after reset");

endmodule

bind ea_select_stage addressing_decode_properties props_i (
    .clk           (clk),
    .rst           (rst),
    .prefix_onehot (prefix_onehot),
    .in_valid      (in_valid),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_data      (out_data)
);

/* tests/addressing_decode_tb.sv */
`timescale 1ns/1ps

module addressing_decode_tb;

    typedef struct {
        string                        name;
        addr_decode_pkg::decode_req_t req;
        addr_decode_pkg::ea_info_t    exp;
    } case_t;

    logic                         clk;
    logic                         rst;
    logic                         in_valid;
    logic                         in_ready;
    addr_decode_pkg::decode_req_t in_data;
    logic                         out_valid;
    logic                         out_ready;
    addr_decode_pkg::ea_info_t    out_data;

    case_t                        cases[$];
    addr_decode_pkg::ea_info_t    exp_q[$];
    string                        name_q[$];
    int                           seed = 59794;
    int                           mismatch_count = 0;
    int                           protocol_count = 0;
    logic                         table_ready = 1'b0;

    addressing_decode addressing_decode_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic addr_decode_pkg::decode_req_t make_req(logic [47:0] bytes,
            logic has_modrm, logic [3:0] prefix, logic two_byte, logic addr16);
        addr_decode_pkg::decode_req_t r;
        r.window        = bytes;
        r.has_modrm     = has_modrm;
        r.prefix_onehot = prefix;
        r.two_byte_op   = two_byte;
        r.addr16        = addr16;
        return r;
    endfunction

    function automatic addr_decode_pkg::ea_info_t make_info(logic [2:0] total, logic [2:0] disp,
            logic [2:0] base, logic [2:0] index, logic ub, logic ui, logic [1:0] sc, logic sib);
        addr_decode_pkg::ea_info_t r;
        r.total_len = total;
        r.disp_len  = disp;
        r.base_reg  = base;
        r.index_reg = index;
        r.use_base  = ub;
        r.use_index = ui;
        r.scale     = sc;
        r.has_sib   = sib;
        return r;
    endfunction

    // reference model of the x86 addressing rules
    function automatic addr_decode_pkg::ea_info_t model_decode(addr_decode_pkg::decode_req_t req);
        addr_decode_pkg::ea_info_t r;
        addr_decode_pkg::modrm_t   m;
        addr_decode_pkg::sib_t     s;
        logic [2:0]                pos;
        r = '0;
        pos = 3'd0;
        for (int i = 0; i < 4; i++) begin
            if (req.prefix_onehot[i]) begin
                pos = 3'(i);
            end
        end
        if (req.two_byte_op) begin
            pos = pos + 3'd1;
        end
        m = req.window[pos].modrm;
        s = req.window[pos + 3'd1].sib;
        if (req.has_modrm) begin
            if (m.mod == 2'b11) begin
                r.base_reg = m.rm;
                r.use_base = 1'b1;
            end else if (req.addr16) begin
                // bx+si bx+di bp+si bp+di si di bp bx
                case (m.rm)
                    3'd0, 3'd1, 3'd7: r.base_reg = addr_decode_pkg::reg_bx;
                    3'd2, 3'd3: r.base_reg = addr_decode_pkg::reg_bp;
                    3'd6: r.base_reg = (m.mod == 2'b00) ? 3'd0 : addr_decode_pkg::reg_bp;
                    default: r.base_reg = 3'd0;
                endcase
                case (m.rm)
                    3'd0, 3'd2, 3'd4: r.index_reg = addr_decode_pkg::reg_si;
                    3'd1, 3'd3, 3'd5: r.index_reg = addr_decode_pkg::reg_di;
                    default: r.index_reg = 3'd0;
                endcase
                r.use_base  = (r.base_reg != 3'd0);
                r.use_index = (r.index_reg != 3'd0);
                if (m.mod == 2'b01) begin
                    r.disp_len = 3'd1;
                end else if (m.mod == 2'b10 || m.rm == 3'd6) begin
                    r.disp_len = 3'd2;
                end
            end else begin
                if (m.rm == 3'd4) begin
                    r.has_sib   = 1'b1;
                    r.base_reg  = s.base;
                    r.index_reg = s.index;
                    r.scale     = s.scale;
                    r.use_base  = 1'b1;
                    r.use_index = 1'b1;
                end else if (!(m.mod == 2'b00 && m.rm == 3'd5)) begin
                    r.base_reg = m.rm;
                    r.use_base = 1'b1;
                end
                if (m.mod == 2'b01) begin
                    r.disp_len = 3'd1;
                end else if (m.mod == 2'b10 || (m.rm == 3'd5 && !r.has_sib)) begin
                    r.disp_len = 3'd4;
                end
            end
            r.total_len = r.disp_len + (r.has_sib ? 3'd2 : 3'd1);
        end
        return r;
    endfunction

    function automatic string fmt_info(addr_decode_pkg::ea_info_t i);
        return $sformatf("len=%0d disp=%0d base=%0d/%0b index=%0d/%0b scale=%0d sib=%0b",
            i.total_len, i.disp_len, i.base_reg, i.use_base, i.index_reg, i.use_index,
            i.scale, i.has_sib);
    endfunction

    task automatic add_case(string name, addr_decode_pkg::decode_req_t req,
            addr_decode_pkg::ea_info_t exp);
        case_t c;
        c.name = name;
        c.req  = req;
        c.exp  = exp;
        cases.push_back(c);
    endtask

    task automatic build_table();
        addr_decode_pkg::decode_req_t req;
        logic [31:0]                  rnd;
        logic [47:0]                  bytes;
        // directed cases
        add_case("r32_reg", make_req(48'h0000_0000_00c3, 1, 4'b0001, 0, 0),
            make_info(3'd1, 3'd0, 3'd3, 3'd0, 1'b1, 1'b0, 2'd0, 1'b0));
        add_case("r32_sib_disp32", make_req(48'h0000_0000_8b84, 1, 4'b0001, 0, 0),
            make_info(3'd6, 3'd4, 3'd3, 3'd1, 1'b1, 1'b1, 2'd2, 1'b1));
        add_case("r32_sib_nodisp", make_req(48'h0000_0000_5804, 1, 4'b0001, 0, 0),
            make_info(3'd2, 3'd0, 3'd0, 3'd3, 1'b1, 1'b1, 2'd1, 1'b1));
        add_case("r32_disp8", make_req(48'h0000_0000_0046, 1, 4'b0001, 0, 0),
            make_info(3'd2, 3'd1, 3'd6, 3'd0, 1'b1, 1'b0, 2'd0, 1'b0));
        add_case("r32_disp32_base", make_req(48'h0000_0000_0081, 1, 4'b0001, 0, 0),
            make_info(3'd5, 3'd4, 3'd1, 3'd0, 1'b1, 1'b0, 2'd0, 1'b0));
        add_case("r32_disp32_only", make_req(48'h0000_0000_0005, 1, 4'b0001, 0, 0),
            make_info(3'd5, 3'd4, 3'd0, 3'd0, 1'b0, 1'b0, 2'd0, 1'b0));
        add_case("r16_disp16_only", make_req(48'h0000_0000_ff06, 1, 4'b0001, 0, 1),
            make_info(3'd3, 3'd2, 3'd0, 3'd0, 1'b0, 1'b0, 2'd0, 1'b0));
        add_case("r16_rm100_no_sib", make_req(48'h0000_0000_8b84, 1, 4'b0001, 0, 1),
            make_info(3'd3, 3'd2, 3'd0, 3'd6, 1'b0, 1'b1, 2'd0, 1'b0));
        add_case("pos_p2_0f_sib", make_req(48'h00d1_44c0_0584, 1, 4'b0100, 1, 0),
            make_info(3'd3, 3'd1, 3'd1, 3'd2, 1'b1, 1'b1, 2'd3, 1'b1));
        add_case("no_modrm", make_req(48'h1d8c_4405_8446, 0, 4'b0010, 1, 0), '0);
        // every 16-bit memory form with a filled sib byte that must be ignored
        for (int md = 0; md < 3; md++) begin
            for (int rm = 0; rm < 8; rm++) begin
                req = make_req({32'h0, 8'he7, 2'(md), 3'b010, 3'(rm)}, 1, 4'b0001, 0, 1);
                add_case($sformatf("r16_mod%0d_rm%0d", md, rm), req, model_decode(req));
            end
        end
        // a different modrm byte sits at each position
        for (int p = 0; p < 4; p++) begin
            for (int t = 0; t < 2; t++) begin
                req = make_req(48'h1d8c_4405_8446, 1, 4'b0001 << p, 1'(t), 0);
                add_case($sformatf("pos_p%0d_t%0d", p, t), req, model_decode(req));
            end
        end
        for (int n = 0; n < 40; n++) begin
            rnd = $random(seed);
            bytes[31:0] = rnd;
            rnd = $random(seed);
            bytes[47:32] = rnd[15:0];
            rnd = $random(seed);
            req = make_req(bytes, rnd[3:2] != 2'b00, 4'b0001 << rnd[1:0], rnd[4], rnd[5]);
            add_case($sformatf("rand_%0d", n), req, model_decode(req));
        end
    endtask

    task automatic check_info(string name, addr_decode_pkg::ea_info_t exp,
            addr_decode_pkg::ea_info_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s: expected %s actual %s", name, fmt_info(exp), fmt_info(act));
        end
    endtask

    task automatic check_handshake(string name, logic exp_valid, logic exp_ready,
            logic act_valid, logic act_ready);
        if (act_valid !== exp_valid || act_ready !== exp_ready) begin
            mismatch_count++;
            $display("mismatch %s: expected valid=%b ready=%b actual valid=%b ready=%b",
                name, exp_valid, exp_ready, act_valid, act_ready);
        end
    endtask

    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = cases.size() * 4 + 50;
        repeat (limit) @(posedge clk);
        $display("timeout: results did not drain within %0d clock cycles", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main
        int          idx;
        logic [31:0] rnd;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        idx       = 0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;
        #1 check_handshake("after_reset", 1'b0, 1'b1, out_valid, in_ready);
        // sample 3 ns after the edge for the transfer on the next edge
        while (idx < cases.size() || exp_q.size() > 0) begin
            @(posedge clk);
            #2;
            rnd = $random(seed);
            out_ready = (rnd[1:0] != 2'b00);
            in_valid  = (idx < cases.size());
            if (in_valid) begin
                in_data = cases[idx].req;
            end
            #1;
            // the output register is full while a result is still owed
            check_handshake("handshake", exp_q.size() > 0, exp_q.size() == 0 || out_ready,
                out_valid, in_ready);
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    protocol_count++;
                    $display("output transfer seen with no request outstanding");
                end else begin
                    check_info(name_q.pop_front(), exp_q.pop_front(), out_data);
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(cases[idx].exp);
                name_q.push_back(cases[idx].name);
                idx++;
            end
        end
        @(posedge clk);
        #2 in_valid = 1'b0;
        out_ready = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #3;
            if (out_valid) begin
                protocol_count++;
                $display("extra result appeared after every request was answered");
            end
        end
        $display("errors: mismatches=%0d protocol=%0d", mismatch_count, protocol_count);
        if (mismatch_count == 0 && protocol_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* addressing_decode.f */
src/addr_decode_pkg.sv
src/ea_length_decode.sv
src/ea_register_decode.sv
src/modrm_decoder.sv
src/ea_select_stage.sv
src/addressing_decode.sv
tests/addressing_decode_properties.sv
tests/addressing_decode_tb.sv

/* run.sh */
#!/bin/sh
# build and run the addressing decode testbench with verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert \
        --top-module addressing_decode_tb \
        -f addressing_decode.f -o addressing_decode_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/addressing_decode_sim > "$log" 2>&1; then
    cat "$log"
    echo "simulation exited with an error"
    exit 1
fi
cat "$log"

if grep -q "Simulation finished: PASS" "$log"; then
    exit 0
else
    echo "pass message not found in $log"
    exit 1
fi
